// File: src/dcache_pkg.sv
package dcache_pkg;

    // Cache geometry, fixed by the 17-bit word address map
    localparam int DATA_W    = 32;
    localparam int TAG_W     = 8;
    localparam int INDEX_W   = 9;
    localparam int ADDR_W    = TAG_W + INDEX_W;
    localparam int NUM_LINES = 1 << INDEX_W;

    typedef logic [DATA_W-1:0]    data_t;
    // One enable per byte, all zero for a read
    typedef logic [DATA_W/8-1:0]  mask_t;
    typedef logic [TAG_W-1:0]     tag_t;
    typedef logic [INDEX_W-1:0]   index_t;

    typedef struct packed {
        tag_t   tag;
        index_t index;
    } word_addr_t;

    typedef struct packed {
        logic       sel;
        word_addr_t addr;
        data_t      wdata;
        mask_t      mask;
    } cpu_req_t;

    typedef struct packed {
        data_t rdata;
        logic  stall;
    } cpu_resp_t;

    typedef struct packed {
        tag_t  tag;
        data_t data;
    } sram_entry_t;

    typedef struct packed {
        logic       valid;
        logic       we;
        word_addr_t addr;
        data_t      wdata;
    } mem_req_t;

    typedef struct packed {
        logic  done;
        data_t rdata;
    } mem_resp_t;

    typedef enum logic [2:0] {
        IDLE,
        CACHE_RD,
        CACHE_WR,
        MEM_RD,
        MEM_WR,
        DONE
    } ctrl_state_e;

endpackage

// File: src/tag_data_sram.sv
`timescale 1ns/1ps

module tag_data_sram (
    input  logic                     clk_i,
    // Write port
    input  logic                     wr_en_i,
    input  dcache_pkg::index_t       wr_index_i,
    input  dcache_pkg::mask_t        wr_mask_i,
    input  dcache_pkg::sram_entry_t  wr_entry_i,
    // Read port
    input  logic                     rd_en_i,
    input  dcache_pkg::index_t       rd_index_i,
    output dcache_pkg::sram_entry_t  rd_entry_o
);

    dcache_pkg::sram_entry_t mem [dcache_pkg::NUM_LINES];
    dcache_pkg::sram_entry_t wr_merged;
    dcache_pkg::sram_entry_t rd_entry_q;

    // Tag always replaced, data bytes only where the mask is set
    always_comb begin
        wr_merged     = mem[wr_index_i];
        wr_merged.tag = wr_entry_i.tag;
        for (int b = 0; b < dcache_pkg::DATA_W / 8; b++) begin
            if (wr_mask_i[b]) begin
                wr_merged.data[8*b +: 8] = wr_entry_i.data[8*b +: 8];
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (wr_en_i) begin
            mem[wr_index_i] <= wr_merged;
        end
    end

    // Registered read, write-first when both ports hit the same entry
    always_ff @(posedge clk_i) begin
        if (rd_en_i) begin
            if (wr_en_i && (wr_index_i == rd_index_i)) begin
                rd_entry_q <= wr_merged;
            end else begin
                rd_entry_q <= mem[rd_index_i];
            end
        end
    end

    assign rd_entry_o = rd_entry_q;

endmodule

// File: src/line_state_table.sv
`timescale 1ns/1ps

module line_state_table (
    input  logic               clk_i,
    input  logic               rst_i,
    // Lookup for the current request
    input  dcache_pkg::index_t lookup_index_i,
    output logic               valid_o,
    output logic               dirty_o,
    // Single update strobe from the controller
    input  logic               upd_en_i,
    input  dcache_pkg::index_t upd_index_i,
    input  logic               upd_valid_i,
    input  logic               upd_dirty_i
);

    logic [dcache_pkg::NUM_LINES-1:0] valid_q;
    logic [dcache_pkg::NUM_LINES-1:0] dirty_q;

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            valid_q <= '0;
            dirty_q <= '0;
        end else if (upd_en_i) begin
            valid_q[upd_index_i] <= upd_valid_i;
            dirty_q[upd_index_i] <= upd_dirty_i;
        end
    end

    assign valid_o = valid_q[lookup_index_i];
    assign dirty_o = dirty_q[lookup_index_i];

    // Dirty bit only ever set alongside valid
    a_dirty_implies_valid: assert property (
        @(posedge clk_i) disable iff (rst_i)
        (dirty_q & ~valid_q) == '0
    );

endmodule

// File: src/dcache_ctrl.sv
`timescale 1ns/1ps

module dcache_ctrl (
    input  logic                     clk_i,
    input  logic                     rst_i,
    // Processor side
    input  dcache_pkg::cpu_req_t     cpu_req_i,
    output dcache_pkg::cpu_resp_t    cpu_resp_o,
    // SRAM ports
    output logic                     sram_wr_en_o,
    output dcache_pkg::index_t       sram_wr_index_o,
    output dcache_pkg::mask_t        sram_wr_mask_o,
    output dcache_pkg::sram_entry_t  sram_wr_entry_o,
    output logic                     sram_rd_en_o,
    output dcache_pkg::index_t       sram_rd_index_o,
    input  dcache_pkg::sram_entry_t  sram_entry_i,
    // Line state lookup and update
    input  logic                     line_valid_i,
    input  logic                     line_dirty_i,
    output logic                     upd_en_o,
    output dcache_pkg::index_t       upd_index_o,
    output logic                     upd_valid_o,
    output logic                     upd_dirty_o,
    // Memory side
    output dcache_pkg::mem_req_t     mem_req_o,
    input  dcache_pkg::mem_resp_t    mem_resp_i
);

    dcache_pkg::ctrl_state_e state_q;
    dcache_pkg::ctrl_state_e state_next;

    logic              is_write;
    logic              is_full;
    logic              tag_hit;
    logic              write_back;
    logic              fill_valid_q;
    dcache_pkg::data_t fill_merged;
    dcache_pkg::data_t fill_q;
    // Line read in CACHE_RD, serves as read data and as the victim
    dcache_pkg::tag_t  line_tag_q;
    dcache_pkg::data_t line_data_q;

    assign is_write   = |cpu_req_i.mask;
    assign is_full    = &cpu_req_i.mask;
    assign tag_hit    = sram_entry_i.tag == cpu_req_i.addr.tag;
    assign write_back = state_q == dcache_pkg::MEM_WR;

    always_comb begin
        state_next = state_q;
        case (state_q)
            dcache_pkg::IDLE: begin
                if (cpu_req_i.sel) begin
                    if (is_write) begin
                        if (line_valid_i && line_dirty_i) begin
                            state_next = dcache_pkg::CACHE_RD;
                        end else if (is_full) begin
                            state_next = dcache_pkg::CACHE_WR;
                        end else begin
                            state_next = dcache_pkg::MEM_RD;
                        end
                    end else if (line_valid_i) begin
                        state_next = dcache_pkg::CACHE_RD;
                    end else begin
                        state_next = dcache_pkg::MEM_RD;
                    end
                end
            end
            dcache_pkg::CACHE_RD: begin
                if (tag_hit) begin
                    state_next = is_write ? dcache_pkg::CACHE_WR : dcache_pkg::DONE;
                end else if (line_dirty_i) begin
                    state_next = dcache_pkg::MEM_WR;
                end else begin
                    state_next = dcache_pkg::MEM_RD;
                end
            end
            dcache_pkg::MEM_WR: begin
                if (mem_resp_i.done) begin
                    state_next = is_full ? dcache_pkg::CACHE_WR : dcache_pkg::MEM_RD;
                end
            end
            dcache_pkg::MEM_RD: begin
                if (mem_resp_i.done) begin
                    state_next = dcache_pkg::CACHE_WR;
                end
            end
            dcache_pkg::CACHE_WR: begin
                // A read fill goes back through the tag compare
                state_next = is_write ? dcache_pkg::DONE : dcache_pkg::CACHE_RD;
            end
            default: begin
                state_next = dcache_pkg::IDLE;
            end
        endcase
    end

    // Fetched word with the written bytes merged in, plain fetch for reads
    always_comb begin
        fill_merged = mem_resp_i.rdata;
        for (int b = 0; b < dcache_pkg::DATA_W / 8; b++) begin
            if (cpu_req_i.mask[b]) begin
                fill_merged[8*b +: 8] = cpu_req_i.wdata[8*b +: 8];
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            state_q      <= dcache_pkg::IDLE;
            fill_valid_q <= 1'b0;
        end else begin
            state_q <= state_next;
            if (state_q == dcache_pkg::MEM_RD && mem_resp_i.done) begin
                fill_valid_q <= 1'b1;
            end else if (state_q == dcache_pkg::DONE) begin
                fill_valid_q <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (state_q == dcache_pkg::CACHE_RD) begin
            line_tag_q  <= sram_entry_i.tag;
            line_data_q <= sram_entry_i.data;
        end
        if (state_q == dcache_pkg::MEM_RD && mem_resp_i.done) begin
            fill_q <= fill_merged;
        end
    end

    // SRAM read issued one cycle ahead of CACHE_RD
    assign sram_rd_en_o    = state_next == dcache_pkg::CACHE_RD;
    assign sram_rd_index_o = cpu_req_i.addr.index;

    // Fill data replaces the whole word, a direct write only its bytes
    assign sram_wr_en_o         = state_q == dcache_pkg::CACHE_WR;
    assign sram_wr_index_o      = cpu_req_i.addr.index;
    assign sram_wr_mask_o       = fill_valid_q ? '1 : cpu_req_i.mask;
    assign sram_wr_entry_o.tag  = cpu_req_i.addr.tag;
    assign sram_wr_entry_o.data = fill_valid_q ? fill_q : cpu_req_i.wdata;

    assign upd_en_o    = state_q == dcache_pkg::CACHE_WR;
    assign upd_index_o = cpu_req_i.addr.index;
    assign upd_valid_o = 1'b1;
    assign upd_dirty_o = is_write;

    always_comb begin
        mem_req_o.valid = (state_q == dcache_pkg::MEM_RD) || write_back;
        mem_req_o.we    = write_back;
        if (write_back) begin
            mem_req_o.addr.tag   = line_tag_q;
            mem_req_o.addr.index = cpu_req_i.addr.index;
            mem_req_o.wdata      = line_data_q;
        end else begin
            mem_req_o.addr  = cpu_req_i.addr;
            mem_req_o.wdata = '0;
        end
    end

    assign cpu_resp_o.rdata = line_data_q;
    assign cpu_resp_o.stall = state_next != dcache_pkg::IDLE;

    // Responses only for a live request, and the FSM moves on right away
    a_done_consumed: assert property (
        @(posedge clk_i) disable iff (rst_i)
        mem_resp_i.done |-> mem_req_o.valid ##1 (state_q != $past(state_q))
    );

    // Victim never belongs to the line being brought in
    a_victim_tag: assert property (
        @(posedge clk_i) disable iff (rst_i)
        write_back |-> mem_req_o.addr.tag != cpu_req_i.addr.tag
    );

endmodule

// File: src/wb_mem_master.sv
`timescale 1ns/1ps

module wb_mem_master (
    input  logic                   clk_i,
    input  logic                   rst_i,
    // Controller side
    input  dcache_pkg::mem_req_t   mem_req_i,
    output dcache_pkg::mem_resp_t  mem_resp_o,
    // Wishbone classic master
    output logic                   wb_cyc_o,
    output logic                   wb_stb_o,
    output logic                   wb_we_o,
    output dcache_pkg::word_addr_t wb_adr_o,
    output dcache_pkg::data_t      wb_dat_o,
    output dcache_pkg::mask_t      wb_sel_o,
    input  dcache_pkg::data_t      wb_dat_i,
    input  logic                   wb_ack_i
);

    // Idle when low, bus cycle in progress when high
    logic                   busy_q;
    logic                   we_q;
    logic                   done_q;
    logic                   start;
    dcache_pkg::word_addr_t adr_q;
    dcache_pkg::data_t      dat_q;
    dcache_pkg::data_t      rdata_q;

    // Request is still held during the done cycle, so don't restart then
    assign start = !busy_q && mem_req_i.valid && !done_q;

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            busy_q <= 1'b0;
            we_q   <= 1'b0;
            done_q <= 1'b0;
        end else begin
            done_q <= 1'b0;
            if (start) begin
                busy_q <= 1'b1;
                we_q   <= mem_req_i.we;
            end else if (busy_q && wb_ack_i) begin
                busy_q <= 1'b0;
                we_q   <= 1'b0;
                done_q <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (start) begin
            adr_q <= mem_req_i.addr;
            dat_q <= mem_req_i.wdata;
        end
        if (busy_q && wb_ack_i) begin
            rdata_q <= wb_dat_i;
        end
    end

    assign wb_cyc_o = busy_q;
    assign wb_stb_o = busy_q;
    assign wb_we_o  = we_q;
    assign wb_adr_o = adr_q;
    assign wb_dat_o = dat_q;
    assign wb_sel_o = '1;

    assign mem_resp_o.done  = done_q;
    assign mem_resp_o.rdata = rdata_q;

    // Slave acks only inside an open bus cycle
    a_ack_in_cycle: assert property (
        @(posedge clk_i) disable iff (rst_i)
        wb_ack_i |-> wb_stb_o
    );

    // Classic cycle holds its address and data until acked
    a_hold_until_ack: assert property (
        @(posedge clk_i) disable iff (rst_i)
        (wb_stb_o && !wb_ack_i) |=>
            $stable(wb_adr_o) && $stable(wb_we_o) && $stable(wb_dat_o)
    );

endmodule

// File: src/dcache_top.sv
`timescale 1ns/1ps

module dcache_top (
    input  logic                   clk_i,
    input  logic                   rst_i,
    // Processor load/store port
    input  dcache_pkg::cpu_req_t   cpu_req_i,
    output dcache_pkg::cpu_resp_t  cpu_resp_o,
    // Wishbone to main memory
    output logic                   wb_cyc_o,
    output logic                   wb_stb_o,
    output logic                   wb_we_o,
    output dcache_pkg::word_addr_t wb_adr_o,
    output dcache_pkg::data_t      wb_dat_o,
    output dcache_pkg::mask_t      wb_sel_o,
    input  dcache_pkg::data_t      wb_dat_i,
    input  logic                   wb_ack_i
);

    logic                    sram_wr_en;
    dcache_pkg::index_t      sram_wr_index;
    dcache_pkg::mask_t       sram_wr_mask;
    dcache_pkg::sram_entry_t sram_wr_entry;
    logic                    sram_rd_en;
    dcache_pkg::index_t      sram_rd_index;
    dcache_pkg::sram_entry_t sram_rd_entry;

    logic                    line_valid;
    logic                    line_dirty;
    logic                    upd_en;
    dcache_pkg::index_t      upd_index;
    logic                    upd_valid;
    logic                    upd_dirty;

    dcache_pkg::mem_req_t    mem_req;
    dcache_pkg::mem_resp_t   mem_resp;

    dcache_ctrl u_ctrl (
        .clk_i           (clk_i),
        .rst_i           (rst_i),
        .cpu_req_i       (cpu_req_i),
        .cpu_resp_o      (cpu_resp_o),
        .sram_wr_en_o    (sram_wr_en),
        .sram_wr_index_o (sram_wr_index),
        .sram_wr_mask_o  (sram_wr_mask),
        .sram_wr_entry_o (sram_wr_entry),
        .sram_rd_en_o    (sram_rd_en),
        .sram_rd_index_o (sram_rd_index),
        .sram_entry_i    (sram_rd_entry),
        .line_valid_i    (line_valid),
        .line_dirty_i    (line_dirty),
        .upd_en_o        (upd_en),
        .upd_index_o     (upd_index),
        .upd_valid_o     (upd_valid),
        .upd_dirty_o     (upd_dirty),
        .mem_req_o       (mem_req),
        .mem_resp_i      (mem_resp)
    );

    tag_data_sram u_sram (
        .clk_i      (clk_i),
        .wr_en_i    (sram_wr_en),
        .wr_index_i (sram_wr_index),
        .wr_mask_i  (sram_wr_mask),
        .wr_entry_i (sram_wr_entry),
        .rd_en_i    (sram_rd_en),
        .rd_index_i (sram_rd_index),
        .rd_entry_o (sram_rd_entry)
    );

    // Lookup follows the request index directly
    line_state_table u_state (
        .clk_i          (clk_i),
        .rst_i          (rst_i),
        .lookup_index_i (cpu_req_i.addr.index),
        .valid_o        (line_valid),
        .dirty_o        (line_dirty),
        .upd_en_i       (upd_en),
        .upd_index_i    (upd_index),
        .upd_valid_i    (upd_valid),
        .upd_dirty_i    (upd_dirty)
    );

    wb_mem_master u_wb_master (
        .clk_i      (clk_i),
        .rst_i      (rst_i),
        .mem_req_i  (mem_req),
        .mem_resp_o (mem_resp),
        .wb_cyc_o   (wb_cyc_o),
        .wb_stb_o   (wb_stb_o),
        .wb_we_o    (wb_we_o),
        .wb_adr_o   (wb_adr_o),
        .wb_dat_o   (wb_dat_o),
        .wb_sel_o   (wb_sel_o),
        .wb_dat_i   (wb_dat_i),
        .wb_ack_i   (wb_ack_i)
    );

endmodule

// File: verification/wb_mem_model.sv
`timescale 1ns/1ps

module wb_mem_model (
    input  logic                   clk_i,
    input  logic                   rst_i,
    // Wishbone classic slave
    input  logic                   wb_cyc_i,
    input  logic                   wb_stb_i,
    input  logic                   wb_we_i,
    input  dcache_pkg::word_addr_t wb_adr_i,
    input  dcache_pkg::data_t      wb_dat_i,
    input  dcache_pkg::mask_t      wb_sel_i,
    output dcache_pkg::data_t      wb_dat_o,
    output logic                   wb_ack_o,
    // One-cycle record of each completed bus cycle
    output logic                   log_wr_o,
    output logic                   log_rd_o,
    output dcache_pkg::word_addr_t log_adr_o,
    output dcache_pkg::data_t      log_dat_o
);

    dcache_pkg::data_t mem [1 << dcache_pkg::ADDR_W];
    dcache_pkg::data_t merged;
    logic [31:0]       lcg_state;
    logic [1:0]        wait_left;

    function automatic dcache_pkg::data_t preload_value(input logic [31:0] a);
        return (a * 32'h9e3779b1) ^ 32'h0f1e2d3c;
    endfunction

    initial begin
        for (int a = 0; a < (1 << dcache_pkg::ADDR_W); a++) begin
            mem[a] = preload_value(a);
        end
    end

    always_comb begin
        merged = mem[wb_adr_i];
        for (int b = 0; b < dcache_pkg::DATA_W / 8; b++) begin
            if (wb_sel_i[b]) begin
                merged[8*b +: 8] = wb_dat_i[8*b +: 8];
            end
        end
    end

    // Ack after 0 to 3 wait states, drawn again for every bus cycle
    always @(posedge clk_i) begin
        wb_ack_o <= 1'b0;
        log_wr_o <= 1'b0;
        log_rd_o <= 1'b0;
        if (rst_i) begin
            lcg_state <= 32'hcbd5;
            wait_left <= 2'd0;
        end else if (wb_cyc_i && wb_stb_i && !wb_ack_o) begin
            if (wait_left != 2'd0) begin
                wait_left <= wait_left - 2'd1;
            end else begin
                wb_ack_o  <= 1'b1;
                log_adr_o <= wb_adr_i;
                lcg_state <= lcg_state * 32'd1664525 + 32'd1013904223;
                wait_left <= lcg_state[17:16];
                if (wb_we_i) begin
                    mem[wb_adr_i] <= merged;
                    log_wr_o      <= 1'b1;
                    log_dat_o     <= merged;
                end else begin
                    wb_dat_o  <= mem[wb_adr_i];
                    log_rd_o  <= 1'b1;
                    log_dat_o <= mem[wb_adr_i];
                end
            end
        end
    end

endmodule

// File: verification/dcache_tb.sv
`timescale 1ns/1ps

module dcache_tb;

    localparam int RESET_CYCLES  = 8;
    localparam int DIRECTED_OPS  = 24;
    localparam int RANDOM_OPS    = 400;
    localparam int FLUSH_OPS     = 16;
    // Worst case is a write-back plus a fill, each with three wait states
    localparam int CYCLES_PER_OP = 40;
    localparam int MAX_CYCLES    =
        (DIRECTED_OPS + RANDOM_OPS + FLUSH_OPS) * CYCLES_PER_OP + RESET_CYCLES + 100;
    localparam dcache_pkg::tag_t FLUSH_TAG = 8'h3c;

    logic                   clk_i;
    logic                   rst_i;
    dcache_pkg::cpu_req_t   cpu_req;
    dcache_pkg::cpu_resp_t  cpu_resp;
    logic                   wb_cyc;
    logic                   wb_stb;
    logic                   wb_we;
    dcache_pkg::word_addr_t wb_adr;
    dcache_pkg::data_t      wb_dat_m2s;
    dcache_pkg::data_t      wb_dat_s2m;
    dcache_pkg::mask_t      wb_sel;
    logic                   wb_ack;
    logic                   log_wr;
    logic                   log_rd;
    dcache_pkg::word_addr_t log_adr;
    dcache_pkg::data_t      log_dat;

    // Latest value of every word, and what each cache line holds
    dcache_pkg::data_t ref_mem [1 << dcache_pkg::ADDR_W];
    dcache_pkg::tag_t  sh_tag [dcache_pkg::NUM_LINES];
    logic              sh_valid [dcache_pkg::NUM_LINES];
    logic              sh_dirty [dcache_pkg::NUM_LINES];

    dcache_pkg::word_addr_t wr_adr_q [$];
    dcache_pkg::data_t      wr_dat_q [$];
    dcache_pkg::word_addr_t rd_adr_q [$];

    logic [31:0] rng_state   = 32'hcbd5;
    int          cycle_count = 0;
    int          check_count = 0;
    int          error_count = 0;
    int          test_checks;
    int          test_errors;

    dcache_top uut (
        .clk_i      (clk_i),
        .rst_i      (rst_i),
        .cpu_req_i  (cpu_req),
        .cpu_resp_o (cpu_resp),
        .wb_cyc_o   (wb_cyc),
        .wb_stb_o   (wb_stb),
        .wb_we_o    (wb_we),
        .wb_adr_o   (wb_adr),
        .wb_dat_o   (wb_dat_m2s),
        .wb_sel_o   (wb_sel),
        .wb_dat_i   (wb_dat_s2m),
        .wb_ack_i   (wb_ack)
    );

    wb_mem_model mem_model (
        .clk_i     (clk_i),
        .rst_i     (rst_i),
        .wb_cyc_i  (wb_cyc),
        .wb_stb_i  (wb_stb),
        .wb_we_i   (wb_we),
        .wb_adr_i  (wb_adr),
        .wb_dat_i  (wb_dat_m2s),
        .wb_sel_i  (wb_sel),
        .wb_dat_o  (wb_dat_s2m),
        .wb_ack_o  (wb_ack),
        .log_wr_o  (log_wr),
        .log_rd_o  (log_rd),
        .log_adr_o (log_adr),
        .log_dat_o (log_dat)
    );

    always #4 clk_i = ~clk_i;

    always @(posedge clk_i) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= MAX_CYCLES) begin
            $display("Timeout: the run did not finish within %0d cycles", MAX_CYCLES);
            $display("TEST FAIL");
            $finish;
        end
    end

    // Bus log pulses last a full cycle, so the falling edge sees them
    always @(negedge clk_i) begin
        if (log_wr) begin
            wr_adr_q.push_back(log_adr);
            wr_dat_q.push_back(log_dat);
        end
        if (log_rd) begin
            rd_adr_q.push_back(log_adr);
        end
    end

    function automatic logic [31:0] next_random();
        rng_state = rng_state * 32'd1664525 + 32'd1013904223;
        return rng_state;
    endfunction

    // Same preload as the memory model
    function automatic dcache_pkg::data_t preload_value(input logic [31:0] a);
        return (a * 32'h9e3779b1) ^ 32'h0f1e2d3c;
    endfunction

    function automatic dcache_pkg::mask_t random_partial_mask();
        logic [31:0] r;
        r = next_random();
        return 4'(1 + r[31:16] % 14);
    endfunction

    // Four tags over sixteen spread-out indexes, so lines conflict often
    function automatic dcache_pkg::word_addr_t make_addr(input logic [1:0] t,
                                                         input logic [3:0] k);
        dcache_pkg::word_addr_t a;
        case (t)
            2'd0:    a.tag = 8'h12;
            2'd1:    a.tag = 8'h5a;
            2'd2:    a.tag = 8'ha7;
            default: a.tag = 8'hf0;
        endcase
        a.index = {k, 5'd7};
        return a;
    endfunction

    function automatic dcache_pkg::data_t merge_bytes(input dcache_pkg::data_t old_word,
                                                      input dcache_pkg::data_t new_word,
                                                      input dcache_pkg::mask_t mask);
        dcache_pkg::data_t w;
        w = old_word;
        for (int b = 0; b < 4; b++) begin
            if (mask[b]) begin
                w[8*b +: 8] = new_word[8*b +: 8];
            end
        end
        return w;
    endfunction

    task automatic check_data(input string what, input dcache_pkg::word_addr_t addr,
                              input dcache_pkg::data_t expected, input dcache_pkg::data_t got);
        check_count++;
        if (got != expected) begin
            error_count++;
            $display("ERROR %s at 0x%05h: expected 0x%08h, got 0x%08h",
                     what, addr, expected, got);
        end
    endtask

    task automatic check_wb_write(input dcache_pkg::word_addr_t exp_adr,
                                  input dcache_pkg::data_t exp_dat);
        dcache_pkg::word_addr_t got_adr;
        dcache_pkg::data_t      got_dat;
        check_count++;
        if (wr_adr_q.size() == 0) begin
            error_count++;
            $display("Missing write-back: no Wishbone write seen for victim 0x%05h", exp_adr);
        end else begin
            got_adr = wr_adr_q.pop_front();
            got_dat = wr_dat_q.pop_front();
            if (got_adr != exp_adr) begin
                error_count++;
                $display("ERROR wb_adr_o: expected 0x%05h, got 0x%05h", exp_adr, got_adr);
            end
            if (got_dat != exp_dat) begin
                error_count++;
                $display("ERROR wb_dat_o: expected 0x%08h, got 0x%08h", exp_dat, got_dat);
            end
        end
    endtask

    task automatic check_wb_read(input dcache_pkg::word_addr_t exp_adr);
        dcache_pkg::word_addr_t got_adr;
        check_count++;
        if (rd_adr_q.size() == 0) begin
            error_count++;
            $display("Missing fill: no Wishbone read seen for 0x%05h", exp_adr);
        end else begin
            got_adr = rd_adr_q.pop_front();
            if (got_adr != exp_adr) begin
                error_count++;
                $display("ERROR wb_adr_o: expected 0x%05h, got 0x%05h", exp_adr, got_adr);
            end
        end
    endtask

    task automatic check_no_traffic();
        check_count++;
        if (wr_adr_q.size() != 0 || rd_adr_q.size() != 0) begin
            error_count++;
            $display("Unexpected Wishbone traffic: %0d extra reads and %0d extra writes",
                     rd_adr_q.size(), wr_adr_q.size());
            wr_adr_q.delete();
            wr_dat_q.delete();
            rd_adr_q.delete();
        end
    endtask

    // One processor access, with bus traffic predicted from the line shadow
    task automatic access(input dcache_pkg::word_addr_t addr, input dcache_pkg::mask_t mask,
                          input dcache_pkg::data_t wdata);
        dcache_pkg::index_t     idx;
        dcache_pkg::word_addr_t victim;
        dcache_pkg::data_t      rdata;
        logic                   hit;
        logic                   evict;
        logic                   fetch;
        idx          = addr.index;
        hit          = sh_valid[idx] && (sh_tag[idx] == addr.tag);
        evict        = sh_valid[idx] && sh_dirty[idx] && !hit;
        victim.tag   = sh_tag[idx];
        victim.index = idx;
        if (mask == 4'h0) begin
            fetch = !hit;
        end else if (mask == 4'hf) begin
            fetch = 1'b0;
        end else begin
            // Partial writes merge into the fetched word unless a dirty copy is here
            fetch = !(hit && sh_dirty[idx]);
        end

        @(negedge clk_i);
        cpu_req.addr  = addr;
        cpu_req.wdata = wdata;
        cpu_req.mask  = mask;
        cpu_req.sel   = 1'b1;
        do begin
            @(negedge clk_i);
        end while (cpu_resp.stall);
        rdata       = cpu_resp.rdata;
        cpu_req.sel = 1'b0;

        if (evict) begin
            check_wb_write(victim, ref_mem[victim]);
        end
        if (fetch) begin
            check_wb_read(addr);
        end
        check_no_traffic();
        ref_mem[addr] = merge_bytes(ref_mem[addr], wdata, mask);
        if (mask == 4'h0) begin
            check_data("cpu_resp_o.rdata", addr, ref_mem[addr], rdata);
        end
        sh_dirty[idx] = (mask != 4'h0) || (hit && sh_dirty[idx]);
        sh_valid[idx] = 1'b1;
        sh_tag[idx]   = addr.tag;
    endtask

    task automatic start_test();
        test_checks = check_count;
        test_errors = error_count;
    endtask

    task automatic finish_test(input string name);
        $display("%s: %0d checks, %0d errors", name, check_count - test_checks,
                 error_count - test_errors);
    endtask

    initial begin
        dcache_pkg::word_addr_t addr;
        logic [31:0]            r;
        clk_i   = 1'b0;
        rst_i   = 1'b1;
        cpu_req = '0;
        for (int a = 0; a < (1 << dcache_pkg::ADDR_W); a++) begin
            ref_mem[a] = preload_value(a);
        end
        for (int i = 0; i < dcache_pkg::NUM_LINES; i++) begin
            sh_valid[i] = 1'b0;
            sh_dirty[i] = 1'b0;
            sh_tag[i]   = '0;
        end
        repeat (RESET_CYCLES) @(posedge clk_i);
        @(negedge clk_i);
        rst_i = 1'b0;

        start_test();
        access(make_addr(2'd0, 4'd0), 4'h0, '0);
        access(make_addr(2'd0, 4'd0), 4'h0, '0);
        finish_test("read_miss_then_hit");

        start_test();
        access(make_addr(2'd1, 4'd1), 4'hf, next_random());
        access(make_addr(2'd1, 4'd1), 4'h0, '0);
        finish_test("full_word_write");

        start_test();
        for (int i = 0; i < 8; i++) begin
            addr = make_addr(2'd2, 4'(i + 2));
            access(addr, random_partial_mask(), next_random());
            access(addr, 4'h0, '0);
        end
        finish_test("partial_write_merge");

        // Read miss over the dirty full-word line, then a full write over a merged one
        start_test();
        access(make_addr(2'd3, 4'd1), 4'h0, '0);
        access(make_addr(2'd0, 4'd2), 4'hf, next_random());
        access(make_addr(2'd1, 4'd1), 4'h0, '0);
        access(make_addr(2'd0, 4'd2), 4'h0, '0);
        finish_test("dirty_eviction");

        start_test();
        for (int n = 0; n < RANDOM_OPS; n++) begin
            r    = next_random();
            addr = make_addr(r[17:16], r[23:20]);
            case (r[25:24])
                2'd2:    access(addr, 4'hf, next_random());
                2'd3:    access(addr, random_partial_mask(), next_random());
                default: access(addr, 4'h0, '0);
            endcase
        end
        finish_test("random_mix");

        // An unused tag at every index pushes all dirty lines out to memory
        start_test();
        for (int k = 0; k < FLUSH_OPS; k++) begin
            addr.tag   = FLUSH_TAG;
            addr.index = {4'(k), 5'd7};
            access(addr, 4'h0, '0);
        end
        for (int t = 0; t < 4; t++) begin
            for (int k = 0; k < 16; k++) begin
                addr = make_addr(2'(t), 4'(k));
                check_data("mem_model.mem", addr, ref_mem[addr], mem_model.mem[addr]);
            end
        end
        finish_test("memory_image");

        $display("Total: %0d checks, %0d errors", check_count, error_count);
        if (error_count == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

// File: dcache.f
src/dcache_pkg.sv
src/tag_data_sram.sv
src/line_state_table.sv
src/dcache_ctrl.sv
src/wb_mem_master.sv
src/dcache_top.sv
verification/wb_mem_model.sv
verification/dcache_tb.sv

// File: Makefile
TOP = dcache_tb

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert --timescale 1ns/1ps --top-module $(TOP) -f dcache.f

obj_dir/V$(TOP): dcache.f src/*.sv verification/*.sv
	verilator --binary --timing --assert --timescale 1ns/1ps --top-module $(TOP) -f dcache.f

sim: obj_dir/V$(TOP)
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "TEST PASS"

clean:
	rm -rf obj_dir
